// File: sources.f
hdl/mont_pkg.sv
hdl/mont_cmd_fsm.sv
hdl/mont_operand_regs.sv
hdl/mont_mult_core.sv
hdl/mont_wrapper.sv
dv/tb_mont_wrapper.sv

// File: run.sh
#!/bin/sh
# Build and run the Montgomery wrapper testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_mont_wrapper -f sources.f \
    && ./obj_dir/Vtb_mont_wrapper > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "All checks passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: dv/tb_mont_wrapper.sv
`timescale 1ns/1ps

module tb_mont_wrapper import mont_pkg::*; ();

    localparam int NUM_TESTS   = 8;
    localparam int WATCHDOG_NS = NUM_TESTS * (OPERAND_WIDTH + 60) * 4;

    logic     clk;
    logic     resetn;
    operand_t bram_din;
    logic     bram_din_valid;
    operand_t bram_dout;
    logic     bram_dout_valid;
    logic     bram_dout_read;
    cmd_t     port1_din;
    logic     port1_valid;
    logic     port1_read;
    logic     port2_valid;
    logic     port2_read;
    state_t   leds;

    // Stimulus table with one column per field
    string    test_name  [NUM_TESTS];
    operand_t tx         [NUM_TESTS];
    operand_t te         [NUM_TESTS];
    operand_t tm         [NUM_TESTS];
    logic     reuse_em   [NUM_TESTS];
    int       dout_delay [NUM_TESTS];
    int       done_delay [NUM_TESTS];
    operand_t expected   [NUM_TESTS];

    integer seed;
    int     error_count;
    int     check_count;

    mont_wrapper DUT (
        .clk             (clk),
        .resetn          (resetn),
        .bram_din        (bram_din),
        .bram_din_valid  (bram_din_valid),
        .bram_dout       (bram_dout),
        .bram_dout_valid (bram_dout_valid),
        .bram_dout_read  (bram_dout_read),
        .port1_din       (port1_din),
        .port1_valid     (port1_valid),
        .port1_read      (port1_read),
        .port2_valid     (port2_valid),
        .port2_read      (port2_read),
        .leds            (leds)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_operand(input string name, input operand_t exp,
                                 input operand_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input state_t exp, input state_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error %s: expected state %0d, actual state %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Radix-2 Montgomery product a*b*2^-W mod n taking one bit of a per step
    function automatic operand_t mont_model(input operand_t a, input operand_t b,
                                            input operand_t n);
        logic [OPERAND_WIDTH+1:0] acc;
        acc = '0;
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            if (a[i]) begin
                acc = acc + {2'b00, b};
            end
            if (acc[0]) begin
                acc = acc + {2'b00, n};
            end
            acc = acc >> 1;
        end
        if (acc >= {2'b00, n}) begin
            acc = acc - {2'b00, n};
        end
        return acc[OPERAND_WIDTH-1:0];
    endfunction

    function automatic operand_t random_operand();
        operand_t v;
        for (int i = 0; i < OPERAND_WIDTH / 32; i++) begin
            v[i*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    task automatic set_entry(input int idx, input string name, input operand_t x,
                             input operand_t e, input operand_t m, input logic reuse,
                             input int dd, input int pd);
        test_name[idx]  = name;
        tx[idx]         = x;
        te[idx]         = e;
        tm[idx]         = m;
        reuse_em[idx]   = reuse;
        dout_delay[idx] = dd;
        done_delay[idx] = pd;
    endtask

    // Retained entries copy e and m of the entry before them
    task automatic build_table();
        operand_t rm;
        operand_t rx;
        operand_t re;
        set_entry(0, "max_modulus", {{(OPERAND_WIDTH-8){1'b1}}, 8'hfd},
                  operand_t'(64'h0123_4567_89ab_cdef), {OPERAND_WIDTH{1'b1}}, 1'b0, 2, 1);
        set_entry(1, "small_modulus", operand_t'(7), operand_t'(11), operand_t'(13),
                  1'b0, 0, 0);
        set_entry(2, "retain_small", operand_t'(12), te[1], tm[1], 1'b1, 3, 2);
        set_entry(3, "x_zero", '0, operand_t'(1234), operand_t'(64'hffff_ffff_ffff_ffc5),
                  1'b0, 1, 0);
        set_entry(4, "e_zero", operand_t'(32'hdead_beef), '0, tm[3], 1'b0, 0, 3);
        rm    = random_operand();
        rm[0] = 1'b1;
        rx    = random_operand() % rm;
        re    = random_operand() % rm;
        set_entry(5, "random_0", rx, re, rm, 1'b0, 1, 1);
        rx    = random_operand() % rm;
        set_entry(6, "random_reuse", rx, te[5], tm[5], 1'b1, 4, 0);
        rm    = random_operand();
        rm[0] = 1'b1;
        rx    = random_operand() % rm;
        re    = random_operand() % rm;
        set_entry(7, "random_1", rx, re, rm, 1'b0, 2, 2);
        for (int i = 0; i < NUM_TESTS; i++) begin
            expected[i] = mont_model(tx[i], te[i], tm[i]);
        end
    endtask

    // Holds the command until port1_read and then checks the state it led to
    task automatic send_command(input string name, input cmd_t cmd, input state_t exp_state);
        port1_din   = cmd;
        port1_valid = 1'b1;
        @(negedge clk);
        while (!port1_read) begin
            @(negedge clk);
        end
        port1_valid = 1'b0;
        check_state(name, exp_state, leds);
    endtask

    task automatic send_data(input operand_t data);
        bram_din       = data;
        bram_din_valid = 1'b1;
        @(negedge clk);
        bram_din_valid = 1'b0;
    endtask

    // port2_read is held back for delay cycles
    task automatic wait_done(input string name, input int delay);
        while (!port2_valid) begin
            @(negedge clk);
        end
        repeat (delay) begin
            @(negedge clk);
            check_bit({name, " port2_valid held"}, 1'b1, port2_valid);
        end
        port2_read = 1'b1;
        @(negedge clk);
        port2_read = 1'b0;
        while (port2_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic load_operand(input string name, input cmd_t cmd, input state_t st,
                                input operand_t data);
        send_command(name, cmd, st);
        send_data(data);
        wait_done(name, 0);
    endtask

    task automatic read_result(input string name, input operand_t exp, input int delay);
        send_command(name, CMD_WRITE, ST_WRITE_RESULT);
        while (!bram_dout_valid) begin
            @(negedge clk);
        end
        check_operand(name, exp, bram_dout);
        repeat (delay) begin
            @(negedge clk);
            check_bit({name, " bram_dout_valid held"}, 1'b1, bram_dout_valid);
            check_operand({name, " held"}, exp, bram_dout);
        end
        bram_dout_read = 1'b1;
        @(negedge clk);
        bram_dout_read = 1'b0;
    endtask

    initial begin
        seed           = 28;
        error_count    = 0;
        check_count    = 0;
        resetn         = 1'b0;
        bram_din       = '0;
        bram_din_valid = 1'b0;
        bram_dout_read = 1'b0;
        port1_din      = '0;
        port1_valid    = 1'b0;
        port2_read     = 1'b0;
        build_table();

        repeat (3) @(negedge clk);
        resetn = 1'b1;
        check_state("reset", ST_WAIT_CMD, leds);
        check_bit("reset port1_read", 1'b0, port1_read);
        check_bit("reset bram_dout_valid", 1'b0, bram_dout_valid);
        check_bit("reset port2_valid", 1'b0, port2_valid);
        check_operand("reset bram_dout", '0, bram_dout);

        // Code 5 is consumed without a done
        send_command("unknown_cmd", 32'd5, ST_WAIT_CMD);
        repeat (20) begin
            @(negedge clk);
            check_bit("unknown_cmd port1_read", 1'b0, port1_read);
            check_bit("unknown_cmd port2_valid", 1'b0, port2_valid);
            check_state("unknown_cmd", ST_WAIT_CMD, leds);
        end

        for (int i = 0; i < NUM_TESTS; i++) begin
            if (!reuse_em[i]) begin
                load_operand(test_name[i], CMD_READ_E, ST_READ_E, te[i]);
                load_operand(test_name[i], CMD_READ_M, ST_READ_M, tm[i]);
            end
            load_operand(test_name[i], CMD_READ_X, ST_READ_X, tx[i]);
            send_command(test_name[i], CMD_MULT_START, ST_MULT_START);
            wait_done(test_name[i], 0);
            read_result(test_name[i], expected[i], dout_delay[i]);
            wait_done(test_name[i], done_delay[i]);
            // Same result again without a new multiply
            read_result({test_name[i], " rewrite"}, expected[i], 0);
            wait_done(test_name[i], 0);
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// File: hdl/mont_wrapper.sv
`timescale 1ns/1ps

module mont_wrapper import mont_pkg::*; (
    input  logic     clk,
    input  logic     resetn,

    // Operand words from the BRAM interface
    input  operand_t bram_din,
    input  logic     bram_din_valid,

    // Result word to the BRAM interface
    output operand_t bram_dout,
    output logic     bram_dout_valid,
    input  logic     bram_dout_read,

    // Host command port
    input  cmd_t     port1_din,
    input  logic     port1_valid,
    output logic     port1_read,

    // Host done port
    output logic     port2_valid,
    input  logic     port2_read,

    // Current state code for debug
    output state_t   leds
);

    logic         load;
    operand_sel_t sel;
    logic         mult_start;
    logic         mult_done;

    operand_t     x;
    operand_t     e;
    operand_t     m;

    mont_cmd_fsm u_fsm (
        .clk             (clk),
        .resetn          (resetn),
        .port1_din       (port1_din),
        .port1_valid     (port1_valid),
        .port1_read      (port1_read),
        .bram_din_valid  (bram_din_valid),
        .bram_dout_valid (bram_dout_valid),
        .bram_dout_read  (bram_dout_read),
        .port2_valid     (port2_valid),
        .port2_read      (port2_read),
        .load            (load),
        .sel             (sel),
        .mult_start      (mult_start),
        .mult_done       (mult_done),
        .leds            (leds)
    );

    mont_operand_regs u_regs (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .sel      (sel),
        .bram_din (bram_din),
        .x        (x),
        .e        (e),
        .m        (m)
    );

    // The core holds its result, so it goes straight to the BRAM output
    mont_mult_core u_core (
        .clk    (clk),
        .resetn (resetn),
        .start  (mult_start),
        .x      (x),
        .e      (e),
        .m      (m),
        .result (bram_dout),
        .done   (mult_done)
    );

endmodule

// File: hdl/mont_mult_core.sv
`timescale 1ns/1ps

module mont_mult_core import mont_pkg::*; (
    input  logic     clk,
    input  logic     resetn,

    input  logic     start,
    input  operand_t x,
    input  operand_t e,
    input  operand_t m,

    output operand_t result,
    output logic     done
);

    // Two guard bits, the running sum stays below 4m
    logic [OPERAND_WIDTH+1:0] acc;
    operand_t                 x_sh;
    operand_t                 e_r;
    operand_t                 m_r;

    logic [ITER_COUNT_WIDTH-1:0] iter_cnt;
    logic                        busy;

    logic [OPERAND_WIDTH+1:0] acc_cur;
    logic [OPERAND_WIDTH+1:0] sum_e;
    logic [OPERAND_WIDTH+1:0] sum_m;
    logic [OPERAND_WIDTH+1:0] acc_next;
    logic [OPERAND_WIDTH+1:0] acc_sub;
    logic                     x_bit;
    operand_t                 e_cur;
    operand_t                 m_cur;
    logic                     reduce;
    logic                     acc_ge_m;

    // The start cycle already runs iteration one on a cleared
    // accumulator and the incoming operands
    assign acc_cur = start ? '0 : acc;
    assign x_bit   = start ? x[0] : x_sh[0];
    assign e_cur   = start ? e : e_r;
    assign m_cur   = start ? m : m_r;

    // One radix-2 step: add e on a set bit, make even with m, halve
    assign sum_e    = acc_cur + (x_bit ? {2'b00, e_cur} : '0);
    assign sum_m    = sum_e + (sum_e[0] ? {2'b00, m_cur} : '0);
    assign acc_next = sum_m >> 1;

    // After W steps the accumulator is below 2m
    assign reduce   = busy && (iter_cnt == ITER_COUNT_WIDTH'(OPERAND_WIDTH));
    assign acc_ge_m = (acc >= {2'b00, m_r});
    assign acc_sub  = acc - {2'b00, m_r};

    // Control and result
    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy     <= 1'b0;
            iter_cnt <= '0;
            done     <= 1'b0;
            result   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                iter_cnt <= ITER_COUNT_WIDTH'(1);
            end else if (reduce) begin
                busy <= 1'b0;
                done <= 1'b1;
                if (acc_ge_m) begin
                    result <= acc_sub[OPERAND_WIDTH-1:0];
                end else begin
                    result <= acc[OPERAND_WIDTH-1:0];
                end
            end else if (busy) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc  <= acc_next;
            x_sh <= x >> 1;
            e_r  <= e;
            m_r  <= m;
        end else if (busy && !reduce) begin
            acc  <= acc_next;
            x_sh <= x_sh >> 1;
        end
    end

endmodule

// File: hdl/mont_operand_regs.sv
`timescale 1ns/1ps

module mont_operand_regs import mont_pkg::*; (
    input  logic         clk,
    input  logic         resetn,

    // Load strobe and target from the sequencer
    input  logic         load,
    input  operand_sel_t sel,
    input  operand_t     bram_din,

    // Operands to the multiplier core
    output operand_t     x,
    output operand_t     e,
    output operand_t     m
);

    // Each register keeps its value until it is loaded again,
    // so e and m can serve several multiplications
    always_ff @(posedge clk) begin
        if (!resetn) begin
            x <= '0;
            e <= '0;
            m <= '0;
        end else if (load) begin
            case (sel)
                SEL_X: begin
                    x <= bram_din;
                end
                SEL_E: begin
                    e <= bram_din;
                end
                SEL_M: begin
                    m <= bram_din;
                end
                default: begin
                    // Unused select code, nothing is written
                    x <= x;
                end
            endcase
        end
    end

endmodule

// File: hdl/mont_cmd_fsm.sv
`timescale 1ns/1ps

module mont_cmd_fsm import mont_pkg::*; (
    input  logic         clk,
    input  logic         resetn,

    // Command port from the host
    input  cmd_t         port1_din,
    input  logic         port1_valid,
    output logic         port1_read,

    // BRAM side handshakes
    input  logic         bram_din_valid,
    output logic         bram_dout_valid,
    input  logic         bram_dout_read,

    // Done notification to the host
    output logic         port2_valid,
    input  logic         port2_read,

    // Operand register control
    output logic         load,
    output operand_sel_t sel,

    // Multiplier core control
    output logic         mult_start,
    input  logic         mult_done,

    output state_t       leds
);

    state_t state;
    state_t next_state;

    logic accept;
    logic in_read;

    // A command is taken once; port1_read masks the cycle in which
    // the host still holds port1_valid after being acknowledged
    assign accept = (state == ST_WAIT_CMD) && port1_valid && !port1_read;

    assign in_read = (state == ST_READ_X) || (state == ST_READ_E) ||
                     (state == ST_READ_M);

    // Next state decode
    always_comb begin
        next_state = state;
        case (state)
            ST_WAIT_CMD: begin
                if (accept) begin
                    case (port1_din)
                        CMD_READ_X:     next_state = ST_READ_X;
                        CMD_READ_E:     next_state = ST_READ_E;
                        CMD_READ_M:     next_state = ST_READ_M;
                        CMD_MULT_START: next_state = ST_MULT_START;
                        CMD_WRITE:      next_state = ST_WRITE_RESULT;
                        // Unknown codes are dropped without a done
                        default:        next_state = ST_WAIT_CMD;
                    endcase
                end
            end

            ST_READ_X, ST_READ_E, ST_READ_M: begin
                if (bram_din_valid) begin
                    next_state = ST_DONE;
                end
            end

            ST_MULT_START: begin
                next_state = ST_MULT_WAIT;
            end

            ST_MULT_WAIT: begin
                if (mult_done) begin
                    next_state = ST_DONE;
                end
            end

            // Leave only after the host has seen the data
            ST_WRITE_RESULT: begin
                if (bram_dout_read && bram_dout_valid) begin
                    next_state = ST_DONE;
                end
            end

            ST_DONE: begin
                if (port2_read && port2_valid) begin
                    next_state = ST_WAIT_CMD;
                end
            end

            default: begin
                next_state = ST_WAIT_CMD;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_WAIT_CMD;
        end else begin
            state <= next_state;
        end
    end

    // Host handshakes follow the current state by one cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            port1_read      <= 1'b0;
            bram_dout_valid <= 1'b0;
            port2_valid     <= 1'b0;
        end else begin
            port1_read      <= accept;
            bram_dout_valid <= (state == ST_WRITE_RESULT);
            port2_valid     <= (state == ST_DONE);
        end
    end

    // Operand load happens in the same cycle as the data strobe
    assign load = in_read && bram_din_valid;

    always_comb begin
        case (state)
            ST_READ_E: sel = SEL_E;
            ST_READ_M: sel = SEL_M;
            default:   sel = SEL_X;
        endcase
    end

    // One cycle wide since ST_MULT_START always moves on
    assign mult_start = (state == ST_MULT_START);

    assign leds = state;

endmodule

// File: hdl/mont_pkg.sv
package mont_pkg;

    // Width of operands, modulus and result
    localparam int OPERAND_WIDTH = 512;

    // Iteration counter has to reach OPERAND_WIDTH itself
    localparam int ITER_COUNT_WIDTH = $clog2(OPERAND_WIDTH + 1);

    localparam int CMD_WIDTH = 32;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [CMD_WIDTH-1:0]     cmd_t;

    // Host command codes on port 1
    // Codes 3, 4 and 5 are unused and ignored
    localparam cmd_t CMD_READ_X     = 32'd0;
    localparam cmd_t CMD_READ_E     = 32'd1;
    localparam cmd_t CMD_READ_M     = 32'd2;
    localparam cmd_t CMD_MULT_START = 32'd6;
    localparam cmd_t CMD_WRITE      = 32'd7;

    // Sequencer states as they appear on the leds
    typedef enum logic [3:0] {
        ST_WAIT_CMD     = 4'd1,
        ST_READ_X       = 4'd2,
        ST_READ_E       = 4'd3,
        ST_READ_M       = 4'd4,
        ST_WRITE_RESULT = 4'd7,
        ST_DONE         = 4'd8,
        ST_MULT_START   = 4'd11,
        ST_MULT_WAIT    = 4'd12
    } state_t;

    // Operand register select
    typedef enum logic [1:0] {
        SEL_X = 2'd0,
        SEL_E = 2'd1,
        SEL_M = 2'd2
    } operand_sel_t;

endpackage
